//--- hdl/uplink_cfg.svh
`ifndef UPLINK_CFG_SVH
`define UPLINK_CFG_SVH

// AXI4-Lite register bus
`define UPL_DATA_W      32
`define UPL_ADDR_W      11
`define UPL_REG_N       2
`define UPL_REG_CTRL    0
`define UPL_REG_STAT    1

// Deserialized word stream and alignment
`define UPL_WORD_W      32
`define UPL_HEADER      2'b01
`define UPL_LOCK_CNT    8
`define UPL_LOSS_CNT    4
`define UPL_CREDIT_MAX  4

// Control register bits
`define CTRL_RST_BIT    0
`define CTRL_POL_BIT    1

// Status register layout, bits 31:26 read as zero
`define STAT_LOCK_BIT   0
`define STAT_SLIP_LSB   1
`define STAT_EC_LSB     6
`define STAT_IC_LSB     8
`define STAT_PERR_LSB   10
`define STAT_DROP_LSB   18

`endif

//--- hdl/uplink_pkg.sv
`include "uplink_cfg.svh"

package uplink_pkg;

  ////////////////////////////////
  // Register bus types
  ////////////////////////////////
  typedef logic [`UPL_DATA_W-1:0]     axi_data_t;
  typedef logic [`UPL_ADDR_W-1:0]     axi_addr_t;
  typedef logic [`UPL_DATA_W/8-1:0]   axi_strb_t;
  typedef logic [1:0]                 axi_resp_t;
  // One bit selects control or status
  typedef logic [$clog2(`UPL_REG_N)-1:0] reg_idx_t;

  // Bus response codes
  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_SLVERR = 2'd2;

  ////////////////////////////////
  // Uplink datapath types
  ////////////////////////////////
  typedef logic [`UPL_WORD_W-1:0]         mgt_word_t;
  // Rotation over a full word
  typedef logic [$clog2(`UPL_WORD_W)-1:0] slip_t;
  typedef logic [1:0]                     field2_t;
  typedef logic [24:0]                    user_data_t;
  typedef logic [7:0]                     count_t;

  // Header search FSM
  typedef enum logic {
    SEARCH,
    LOCKED
  } align_state_t;

  // Write channel FSM
  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } axi_wr_state_t;

endpackage

//--- hdl/reg_bus_if.sv
`timescale 1ns/1ns

interface reg_bus_if;

  // Write strobe side, one-cycle pulse per accepted write
  logic                  wr_en;
  uplink_pkg::reg_idx_t  wr_idx;
  uplink_pkg::axi_data_t wr_data;
  uplink_pkg::axi_strb_t wr_strb;

  // Read side, data is combinational from the index
  uplink_pkg::reg_idx_t  rd_idx;
  uplink_pkg::axi_data_t rd_data;

  // AXI slave side
  modport master (output wr_en, wr_idx, wr_data, wr_strb, rd_idx, input rd_data);

  // Register block side
  modport slave (input wr_en, wr_idx, wr_data, wr_strb, rd_idx, output rd_data);

endinterface

//--- hdl/axil_reg_slave.sv
`timescale 1ns/1ns
`include "uplink_cfg.svh"

module axil_reg_slave (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  // Write address and data channels
  input  uplink_pkg::axi_addr_t s_axi_awaddr_i,
  input  logic                  s_axi_awvalid_i,
  output logic                  s_axi_awready_o,
  input  uplink_pkg::axi_data_t s_axi_wdata_i,
  input  uplink_pkg::axi_strb_t s_axi_wstrb_i,
  input  logic                  s_axi_wvalid_i,
  output logic                  s_axi_wready_o,
  // Write response channel
  output uplink_pkg::axi_resp_t s_axi_bresp_o,
  output logic                  s_axi_bvalid_o,
  input  logic                  s_axi_bready_i,
  // Read channels
  input  uplink_pkg::axi_addr_t s_axi_araddr_i,
  input  logic                  s_axi_arvalid_i,
  output logic                  s_axi_arready_o,
  output uplink_pkg::axi_data_t s_axi_rdata_o,
  output uplink_pkg::axi_resp_t s_axi_rresp_o,
  output logic                  s_axi_rvalid_o,
  input  logic                  s_axi_rready_i,
  // Register strobes
  reg_bus_if.master             bus
);

  // Byte offset bits below the word index
  localparam int WORD_LSB = $clog2(`UPL_DATA_W / 8);
  localparam int WORD_W   = `UPL_ADDR_W - WORD_LSB;

  uplink_pkg::axi_wr_state_t wr_state;
  logic [WORD_W-1:0]         aw_word;
  logic [WORD_W-1:0]         ar_word;
  logic                      aw_hit;
  logic                      ar_hit;
  logic                      wr_fire;
  logic                      rd_fire;

  // Word decode, anything at or above the register count is a hole
  assign aw_word = s_axi_awaddr_i[`UPL_ADDR_W-1:WORD_LSB];
  assign ar_word = s_axi_araddr_i[`UPL_ADDR_W-1:WORD_LSB];
  assign aw_hit  = aw_word < `UPL_REG_N;
  assign ar_hit  = ar_word < `UPL_REG_N;

  //////////////////////////////
  // Write channel
  //////////////////////////////

  // Address and data taken together, only with no response pending
  assign wr_fire         = (wr_state == uplink_pkg::WR_IDLE) && s_axi_awvalid_i && s_axi_wvalid_i;
  assign s_axi_awready_o = wr_fire;
  assign s_axi_wready_o  = wr_fire;
  assign s_axi_bvalid_o  = (wr_state == uplink_pkg::WR_RESP);

  // Strobe goes out in the handshake cycle
  assign bus.wr_en   = wr_fire && aw_hit;
  assign bus.wr_idx  = aw_word[$bits(uplink_pkg::reg_idx_t)-1:0];
  assign bus.wr_data = s_axi_wdata_i;
  assign bus.wr_strb = s_axi_wstrb_i;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_state <= uplink_pkg::WR_IDLE;
    end else if (wr_fire) begin
      wr_state <= uplink_pkg::WR_RESP;
    end else if (s_axi_bvalid_o && s_axi_bready_i) begin
      wr_state <= uplink_pkg::WR_IDLE;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_fire) begin
      s_axi_bresp_o <= aw_hit ? uplink_pkg::RESP_OKAY : uplink_pkg::RESP_SLVERR;
    end
  end

  //////////////////////////////
  // Read channel
  //////////////////////////////

  // RVALID doubles as the pending-read flag
  assign rd_fire         = s_axi_arvalid_i && !s_axi_rvalid_o;
  assign s_axi_arready_o = rd_fire;
  assign bus.rd_idx      = ar_word[$bits(uplink_pkg::reg_idx_t)-1:0];

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      s_axi_rvalid_o <= 1'b0;
    end else if (rd_fire) begin
      s_axi_rvalid_o <= 1'b1;
    end else if (s_axi_rready_i) begin
      s_axi_rvalid_o <= 1'b0;
    end
  end

  // Holes read back as zero
  always_ff @(posedge S_AXI_ACLK) begin
    if (rd_fire) begin
      s_axi_rdata_o <= ar_hit ? bus.rd_data : '0;
      s_axi_rresp_o <= ar_hit ? uplink_pkg::RESP_OKAY : uplink_pkg::RESP_SLVERR;
    end
  end

  // Response is held until the master takes it
  a_bvalid_hold : assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o);

  // A register strobe only for a valid index, answered with OKAY
  a_wr_en_okay : assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    bus.wr_en |-> aw_hit ##1 (s_axi_bvalid_o && s_axi_bresp_o == uplink_pkg::RESP_OKAY));

endmodule

//--- hdl/uplink_regs.sv
`timescale 1ns/1ns
`include "uplink_cfg.svh"

module uplink_regs (
  input  logic                 S_AXI_ACLK,
  input  logic                 S_AXI_ARESETN,
  // Status sources
  input  logic                 locked_i,
  input  uplink_pkg::slip_t    slip_i,
  input  uplink_pkg::field2_t  ec_i,
  input  uplink_pkg::field2_t  ic_i,
  input  uplink_pkg::count_t   perr_cnt_i,
  input  uplink_pkg::count_t   drop_cnt_i,
  // Register strobes from the AXI slave
  reg_bus_if.slave             bus,
  // Control outputs
  output logic                 uplink_rst_o,
  output logic                 rx_polarity_o
);

  uplink_pkg::axi_data_t ctrl_q;
  uplink_pkg::axi_data_t status;

  //////////////////////////////
  // Control register
  //////////////////////////////

  // Per-byte update, status index writes fall through
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      ctrl_q <= '0;
    end else if (bus.wr_en && bus.wr_idx == `UPL_REG_CTRL) begin
      for (int b = 0; b < `UPL_DATA_W / 8; b++) begin
        if (bus.wr_strb[b]) begin
          ctrl_q[8*b +: 8] <= bus.wr_data[8*b +: 8];
        end
      end
    end
  end

  assign uplink_rst_o  = ctrl_q[`CTRL_RST_BIT];
  assign rx_polarity_o = ctrl_q[`CTRL_POL_BIT];

  //////////////////////////////
  // Status packing and readback
  //////////////////////////////
  always_comb begin
    status = '0;
    status[`STAT_LOCK_BIT]                           = locked_i;
    status[`STAT_SLIP_LSB +: $bits(uplink_pkg::slip_t)] = slip_i;
    status[`STAT_EC_LSB +: 2]                        = ec_i;
    status[`STAT_IC_LSB +: 2]                        = ic_i;
    status[`STAT_PERR_LSB +: 8]                      = perr_cnt_i;
    status[`STAT_DROP_LSB +: 8]                      = drop_cnt_i;
  end

  // Two registers only, so the index picks one or the other
  assign bus.rd_data = (bus.rd_idx == `UPL_REG_STAT) ? status : ctrl_q;

endmodule

//--- hdl/frame_aligner.sv
`timescale 1ns/1ns
`include "uplink_cfg.svh"

module frame_aligner (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  input  logic                  uplink_rst_i,
  input  logic                  rx_polarity_i,
  // Raw deserialized stream
  input  uplink_pkg::mgt_word_t mgt_word_i,
  input  logic                  mgt_valid_i,
  // Aligned stream and status
  output uplink_pkg::mgt_word_t aligned_word_o,
  output logic                  aligned_valid_o,
  output logic                  locked_o,
  output uplink_pkg::slip_t     slip_o
);

  localparam int W      = `UPL_WORD_W;
  localparam int GOOD_W = $clog2(`UPL_LOCK_CNT);
  localparam int BAD_W  = $clog2(`UPL_LOSS_CNT);

  uplink_pkg::align_state_t state;
  uplink_pkg::slip_t        slip;
  logic [GOOD_W-1:0]        good_cnt;
  logic [BAD_W-1:0]         bad_cnt;
  uplink_pkg::mgt_word_t    pol_word;
  logic [2*W-1:0]           rot_pair;
  uplink_pkg::mgt_word_t    rot_word;
  logic                     header_ok;

  // Polarity flip then rotate left by the current slip
  assign pol_word  = mgt_word_i ^ {W{rx_polarity_i}};
  assign rot_pair  = {pol_word, pol_word} << slip;
  assign rot_word  = rot_pair[2*W-1:W];
  assign header_ok = (rot_word[W-1 -: 2] == `UPL_HEADER);

  //////////////////////////////
  // Header search FSM
  //////////////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN || uplink_rst_i) begin
      state           <= uplink_pkg::SEARCH;
      slip            <= '0;
      good_cnt        <= '0;
      bad_cnt         <= '0;
      aligned_valid_o <= 1'b0;
    end else begin
      // Only words checked while locked go downstream
      aligned_valid_o <= mgt_valid_i && (state == uplink_pkg::LOCKED);
      if (mgt_valid_i) begin
        case (state)
          uplink_pkg::SEARCH: begin
            if (!header_ok) begin
              // Slip one bit, used from the next word on
              good_cnt <= '0;
              slip     <= slip + 1'b1;
            end else if (good_cnt == GOOD_W'(`UPL_LOCK_CNT - 1)) begin
              good_cnt <= '0;
              bad_cnt  <= '0;
              state    <= uplink_pkg::LOCKED;
            end else begin
              good_cnt <= good_cnt + 1'b1;
            end
          end
          default: begin
            if (header_ok) begin
              bad_cnt <= '0;
            end else if (bad_cnt == BAD_W'(`UPL_LOSS_CNT - 1)) begin
              bad_cnt <= '0;
              state   <= uplink_pkg::SEARCH;
            end else begin
              bad_cnt <= bad_cnt + 1'b1;
            end
          end
        endcase
      end
    end
  end

  // Word register, no reset on payload
  always_ff @(posedge S_AXI_ACLK) begin
    if (mgt_valid_i) begin
      aligned_word_o <= rot_word;
    end
  end

  assign locked_o = (state == uplink_pkg::LOCKED);
  assign slip_o   = slip;

  // Bit position frozen for as long as the lock holds
  a_slip_locked : assert property (@(posedge S_AXI_ACLK)
    disable iff (!S_AXI_ARESETN || uplink_rst_i)
    locked_o |=> $stable(slip));

endmodule

//--- hdl/frame_decoder.sv
`timescale 1ns/1ns
`include "uplink_cfg.svh"

module frame_decoder (
  input  logic                   S_AXI_ACLK,
  input  logic                   S_AXI_ARESETN,
  input  logic                   uplink_rst_i,
  // Aligned frames
  input  uplink_pkg::mgt_word_t  aligned_word_i,
  input  logic                   aligned_valid_i,
  // One credit back per pulse
  input  logic                   credit_i,
  // User data, one pulse per frame
  output uplink_pkg::user_data_t user_data_o,
  output logic                   user_valid_o,
  // Status fields
  output uplink_pkg::field2_t    ec_o,
  output uplink_pkg::field2_t    ic_o,
  output uplink_pkg::count_t     perr_cnt_o,
  output uplink_pkg::count_t     drop_cnt_o
);

  localparam int CRED_W = $clog2(`UPL_CREDIT_MAX + 1);

  logic [CRED_W-1:0] credits;
  logic              has_credit;
  logic              deliver;
  logic              drop;
  logic              perr;

  // Bit 0 carries even parity over 31:1, so the whole word XORs to zero
  assign perr       = ^aligned_word_i;
  assign has_credit = (credits != '0);
  assign deliver    = aligned_valid_i && has_credit;
  assign drop       = aligned_valid_i && !has_credit;

  //////////////////////////////
  // Credits, counters, fields
  //////////////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN || uplink_rst_i) begin
      credits      <= CRED_W'(`UPL_CREDIT_MAX);
      user_valid_o <= 1'b0;
      ec_o         <= '0;
      ic_o         <= '0;
      perr_cnt_o   <= '0;
      drop_cnt_o   <= '0;
    end else begin
      user_valid_o <= deliver;
      // Returned credit saturates at the maximum
      if (deliver && !credit_i) begin
        credits <= credits - 1'b1;
      end else if (credit_i && !deliver && credits != CRED_W'(`UPL_CREDIT_MAX)) begin
        credits <= credits + 1'b1;
      end
      if (aligned_valid_i) begin
        ic_o <= aligned_word_i[29:28];
        ec_o <= aligned_word_i[27:26];
      end
      // Parity errors still go out, only counted
      if (aligned_valid_i && perr && perr_cnt_o != '1) begin
        perr_cnt_o <= perr_cnt_o + 1'b1;
      end
      if (drop && drop_cnt_o != '1) begin
        drop_cnt_o <= drop_cnt_o + 1'b1;
      end
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (deliver) begin
      user_data_o <= aligned_word_i[25:1];
    end
  end

  // Every frame issued was backed by a credit in the cycle before
  a_credit_used : assert property (@(posedge S_AXI_ACLK)
    disable iff (!S_AXI_ARESETN || uplink_rst_i)
    user_valid_o |-> $past(credits) != '0);

endmodule

//--- hdl/uplink_top.sv
`timescale 1ns/1ns

module uplink_top (
  input  logic                   S_AXI_ACLK,
  input  logic                   S_AXI_ARESETN,
  // AXI4-Lite register port
  input  uplink_pkg::axi_addr_t  s_axi_awaddr_i,
  input  logic                   s_axi_awvalid_i,
  output logic                   s_axi_awready_o,
  input  uplink_pkg::axi_data_t  s_axi_wdata_i,
  input  uplink_pkg::axi_strb_t  s_axi_wstrb_i,
  input  logic                   s_axi_wvalid_i,
  output logic                   s_axi_wready_o,
  output uplink_pkg::axi_resp_t  s_axi_bresp_o,
  output logic                   s_axi_bvalid_o,
  input  logic                   s_axi_bready_i,
  input  uplink_pkg::axi_addr_t  s_axi_araddr_i,
  input  logic                   s_axi_arvalid_i,
  output logic                   s_axi_arready_o,
  output uplink_pkg::axi_data_t  s_axi_rdata_o,
  output uplink_pkg::axi_resp_t  s_axi_rresp_o,
  output logic                   s_axi_rvalid_o,
  input  logic                   s_axi_rready_i,
  // Deserialized word stream
  input  uplink_pkg::mgt_word_t  mgt_word_i,
  input  logic                   mgt_valid_i,
  // Downstream user data with credits
  input  logic                   credit_i,
  output uplink_pkg::user_data_t user_data_o,
  output logic                   user_valid_o,
  output logic                   locked_o
);

  reg_bus_if bus ();

  logic                  uplink_rst;
  logic                  rx_polarity;
  uplink_pkg::mgt_word_t aligned_word;
  logic                  aligned_valid;
  uplink_pkg::slip_t     slip;
  uplink_pkg::field2_t   ec;
  uplink_pkg::field2_t   ic;
  uplink_pkg::count_t    perr_cnt;
  uplink_pkg::count_t    drop_cnt;

  //////////////////////////////
  // Register access
  //////////////////////////////
  axil_reg_slave i_axil_reg_slave (
    .S_AXI_ACLK      (S_AXI_ACLK),
    .S_AXI_ARESETN   (S_AXI_ARESETN),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .bus             (bus.master)
  );

  uplink_regs i_uplink_regs (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .locked_i      (locked_o),
    .slip_i        (slip),
    .ec_i          (ec),
    .ic_i          (ic),
    .perr_cnt_i    (perr_cnt),
    .drop_cnt_i    (drop_cnt),
    .bus           (bus.slave),
    .uplink_rst_o  (uplink_rst),
    .rx_polarity_o (rx_polarity)
  );

  //////////////////////////////
  // Uplink datapath
  //////////////////////////////

  // Two cycles from input word to user data
  frame_aligner i_frame_aligner (
    .S_AXI_ACLK      (S_AXI_ACLK),
    .S_AXI_ARESETN   (S_AXI_ARESETN),
    .uplink_rst_i    (uplink_rst),
    .rx_polarity_i   (rx_polarity),
    .mgt_word_i      (mgt_word_i),
    .mgt_valid_i     (mgt_valid_i),
    .aligned_word_o  (aligned_word),
    .aligned_valid_o (aligned_valid),
    .locked_o        (locked_o),
    .slip_o          (slip)
  );

  frame_decoder i_frame_decoder (
    .S_AXI_ACLK      (S_AXI_ACLK),
    .S_AXI_ARESETN   (S_AXI_ARESETN),
    .uplink_rst_i    (uplink_rst),
    .aligned_word_i  (aligned_word),
    .aligned_valid_i (aligned_valid),
    .credit_i        (credit_i),
    .user_data_o     (user_data_o),
    .user_valid_o    (user_valid_o),
    .ec_o            (ec),
    .ic_o            (ic),
    .perr_cnt_o      (perr_cnt),
    .drop_cnt_o      (drop_cnt)
  );

endmodule

//--- tb/tb_uplink_top.sv
`timescale 1ns/1ns
`include "uplink_cfg.svh"

module tb_uplink_top;

  // Step operations
  localparam logic [1:0] OP_WR  = 2'd0;
  localparam logic [1:0] OP_RD  = 2'd1;
  localparam logic [1:0] OP_FRM = 2'd2;
  localparam logic [1:0] OP_CRD = 2'd3;

  // Frame flags carried in the data column
  localparam int F_PERR = 1;
  localparam int F_INV  = 2;
  localparam int F_HDR  = 4;

  localparam uplink_pkg::axi_resp_t R_OK  = uplink_pkg::RESP_OKAY;
  localparam uplink_pkg::axi_resp_t R_ERR = uplink_pkg::RESP_SLVERR;
  localparam int STAT_ADDR = 4;
  // Cycles allowed for one bus handshake
  localparam int HS_LIMIT  = 20;

  // Op, address or offset, data or flags, strobe or count, expected data and response
  typedef struct packed {
    logic [1:0]            op;
    uplink_pkg::axi_addr_t addr;
    uplink_pkg::axi_data_t data;
    logic [7:0]            cnt;
    uplink_pkg::axi_data_t exp;
    uplink_pkg::axi_resp_t resp;
  } step_t;

  logic                   S_AXI_ACLK;
  logic                   S_AXI_ARESETN;
  uplink_pkg::axi_addr_t  s_axi_awaddr_i;
  logic                   s_axi_awvalid_i;
  logic                   s_axi_awready_o;
  uplink_pkg::axi_data_t  s_axi_wdata_i;
  uplink_pkg::axi_strb_t  s_axi_wstrb_i;
  logic                   s_axi_wvalid_i;
  logic                   s_axi_wready_o;
  uplink_pkg::axi_resp_t  s_axi_bresp_o;
  logic                   s_axi_bvalid_o;
  logic                   s_axi_bready_i;
  uplink_pkg::axi_addr_t  s_axi_araddr_i;
  logic                   s_axi_arvalid_i;
  logic                   s_axi_arready_o;
  uplink_pkg::axi_data_t  s_axi_rdata_o;
  uplink_pkg::axi_resp_t  s_axi_rresp_o;
  logic                   s_axi_rvalid_o;
  logic                   s_axi_rready_i;
  uplink_pkg::mgt_word_t  mgt_word_i;
  logic                   mgt_valid_i;
  logic                   credit_i;
  uplink_pkg::user_data_t user_data_o;
  logic                   user_valid_o;
  logic                   locked_o;

  // Reference model of aligner and decoder
  uplink_pkg::axi_data_t  m_ctrl;
  logic                   m_locked;
  uplink_pkg::slip_t      m_slip;
  int                     m_good;
  int                     m_bad;
  uplink_pkg::field2_t    m_ec;
  uplink_pkg::field2_t    m_ic;
  uplink_pkg::count_t     m_perr;
  uplink_pkg::count_t     m_drop;
  int                     m_credits;
  uplink_pkg::user_data_t exp_q[$];

  step_t                  steps[$];
  logic [31:0]            lcg_state;
  int                     cycle_cnt;
  int                     cycle_limit;

  uplink_top i_dut (.*);

  initial begin
    S_AXI_ACLK = 1'b0;
    forever begin
      #10 S_AXI_ACLK = ~S_AXI_ACLK;
    end
  end

  //////////////////////////////
  // Failure handling and checks
  //////////////////////////////
  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input uplink_pkg::axi_data_t got,
                            input uplink_pkg::axi_data_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input uplink_pkg::axi_resp_t got,
                            input uplink_pkg::axi_resp_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_user(input string name, input uplink_pkg::user_data_t got,
                            input uplink_pkg::user_data_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%07h expected 0x%07h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // Run limit from the table length
  always @(posedge S_AXI_ACLK) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout: run went past %0d cycles", cycle_limit);
      abort_run();
    end
  end

  // Delivered frames checked against the queue at the falling edge
  always @(negedge S_AXI_ACLK) begin
    if (S_AXI_ARESETN && user_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected frame: user_valid_o high with no frame due");
        abort_run();
      end else begin
        check_user("user_data_o", user_data_o, exp_q.pop_front());
      end
    end
  end

  //////////////////////////////
  // Frame building
  //////////////////////////////
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic uplink_pkg::mgt_word_t rotl(input uplink_pkg::mgt_word_t w, input int n);
    return (w << n) | (w >> (`UPL_WORD_W - n));
  endfunction

  function automatic uplink_pkg::mgt_word_t rotr(input uplink_pkg::mgt_word_t w, input int n);
    return (w >> n) | (w << (`UPL_WORD_W - n));
  endfunction

  // Header, IC, EC, user data, even parity in bit 0
  function automatic uplink_pkg::mgt_word_t make_frame(input int flags);
    logic [31:0] r;
    logic [1:0]  hdr;
    logic [30:0] body;
    r    = lcg_next();
    hdr  = ((flags & F_HDR) != 0) ? 2'b10 : `UPL_HEADER;
    body = {hdr, r[5:4], r[3:2], r[31:7]};
    return {body, ^body ^ ((flags & F_PERR) != 0)};
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////
  task automatic clear_uplink_model();
    m_locked  = 1'b0;
    m_slip    = '0;
    m_good    = 0;
    m_bad     = 0;
    m_ec      = '0;
    m_ic      = '0;
    m_perr    = '0;
    m_drop    = '0;
    m_credits = `UPL_CREDIT_MAX;
  endtask

  task automatic apply_ctrl_write(input uplink_pkg::axi_data_t data,
                                  input uplink_pkg::axi_strb_t strb);
    int b;
    for (b = 0; b < 4; b++) begin
      if (strb[b]) begin
        m_ctrl[8*b +: 8] = data[8*b +: 8];
      end
    end
    // Uplink reset level
    if (m_ctrl[`CTRL_RST_BIT]) begin
      clear_uplink_model();
    end
  endtask

  // One raw word through header search and decoding
  task automatic predict_word(input uplink_pkg::mgt_word_t w,
                              input uplink_pkg::mgt_word_t frame);
    uplink_pkg::mgt_word_t rw;
    logic                  ok;
    logic                  passed;
    rw     = rotl(w ^ {`UPL_WORD_W{m_ctrl[`CTRL_POL_BIT]}}, m_slip);
    ok     = (rw[31:30] == `UPL_HEADER);
    passed = m_locked;
    if (!m_locked) begin
      if (!ok) begin
        m_good = 0;
        m_slip = m_slip + 1'b1;
      end else if (m_good == `UPL_LOCK_CNT - 1) begin
        m_good   = 0;
        m_bad    = 0;
        m_locked = 1'b1;
      end else begin
        m_good = m_good + 1;
      end
    end else if (ok) begin
      m_bad = 0;
    end else if (m_bad == `UPL_LOSS_CNT - 1) begin
      m_bad    = 0;
      m_locked = 1'b0;
    end else begin
      m_bad = m_bad + 1;
    end
    // Decoder sees only words checked while locked
    // Fields come from the frame as it was built
    if (passed) begin
      m_ic = frame[29:28];
      m_ec = frame[27:26];
      if (^frame && m_perr != 8'hff) begin
        m_perr = m_perr + 1'b1;
      end
      if (m_credits > 0) begin
        m_credits = m_credits - 1;
        exp_q.push_back(frame[25:1]);
      end else if (m_drop != 8'hff) begin
        m_drop = m_drop + 1'b1;
      end
    end
  endtask

  function automatic uplink_pkg::axi_data_t expected_status();
    uplink_pkg::axi_data_t s;
    s = '0;
    s[`STAT_LOCK_BIT]                              = m_locked;
    s[`STAT_SLIP_LSB +: $bits(uplink_pkg::slip_t)] = m_slip;
    s[`STAT_EC_LSB +: 2]                           = m_ec;
    s[`STAT_IC_LSB +: 2]                           = m_ic;
    s[`STAT_PERR_LSB +: 8]                         = m_perr;
    s[`STAT_DROP_LSB +: 8]                         = m_drop;
    return s;
  endfunction

  //////////////////////////////
  // Bus and stream drivers
  //////////////////////////////

  // All drivers start and end 2 ns after a rising edge
  task automatic axi_write(input uplink_pkg::axi_addr_t addr, input uplink_pkg::axi_data_t data,
                           input uplink_pkg::axi_strb_t strb, input uplink_pkg::axi_resp_t resp);
    int n;
    s_axi_awaddr_i  = addr;
    s_axi_wdata_i   = data;
    s_axi_wstrb_i   = strb;
    s_axi_awvalid_i = 1'b1;
    s_axi_wvalid_i  = 1'b1;
    n = 0;
    @(negedge S_AXI_ACLK);
    while (!(s_axi_awready_o && s_axi_wready_o)) begin
      n++;
      if (n > HS_LIMIT) begin
        $display("Write handshake missing: address and data never accepted");
        abort_run();
      end
      @(negedge S_AXI_ACLK);
    end
    @(posedge S_AXI_ACLK);
    #2;
    s_axi_awvalid_i = 1'b0;
    s_axi_wvalid_i  = 1'b0;
    n = 0;
    @(negedge S_AXI_ACLK);
    while (!s_axi_bvalid_o) begin
      n++;
      if (n > HS_LIMIT) begin
        $display("Write response missing: BVALID never rose");
        abort_run();
      end
      @(negedge S_AXI_ACLK);
    end
    check_resp("s_axi_bresp_o", s_axi_bresp_o, resp);
    @(posedge S_AXI_ACLK);
    #2;
  endtask

  task automatic axi_read(input uplink_pkg::axi_addr_t addr, input uplink_pkg::axi_data_t exp,
                          input uplink_pkg::axi_resp_t resp);
    int n;
    s_axi_araddr_i  = addr;
    s_axi_arvalid_i = 1'b1;
    n = 0;
    @(negedge S_AXI_ACLK);
    while (!s_axi_arready_o) begin
      n++;
      if (n > HS_LIMIT) begin
        $display("Read handshake missing: address never accepted");
        abort_run();
      end
      @(negedge S_AXI_ACLK);
    end
    @(posedge S_AXI_ACLK);
    #2;
    s_axi_arvalid_i = 1'b0;
    n = 0;
    @(negedge S_AXI_ACLK);
    while (!s_axi_rvalid_o) begin
      n++;
      if (n > HS_LIMIT) begin
        $display("Read data missing: RVALID never rose");
        abort_run();
      end
      @(negedge S_AXI_ACLK);
    end
    check_data("s_axi_rdata_o", s_axi_rdata_o, exp);
    check_resp("s_axi_rresp_o", s_axi_rresp_o, resp);
    @(posedge S_AXI_ACLK);
    #2;
  endtask

  // Back-to-back words rotated right by the offset
  task automatic send_frames(input int offset, input int flags, input int count);
    uplink_pkg::mgt_word_t f;
    uplink_pkg::mgt_word_t w;
    for (int i = 0; i < count; i++) begin
      f = make_frame(flags);
      w = rotr(f, offset);
      if ((flags & F_INV) != 0) begin
        w = ~w;
      end
      predict_word(w, f);
      mgt_word_i  = w;
      mgt_valid_i = 1'b1;
      @(posedge S_AXI_ACLK);
      #2;
    end
    mgt_valid_i = 1'b0;
    mgt_word_i  = '0;
    // Two pipeline stages plus margin
    repeat (4) @(posedge S_AXI_ACLK);
    #2;
    if (exp_q.size() != 0) begin
      $display("Missing frame: %0d expected user words never delivered", exp_q.size());
      abort_run();
    end
    check_flag("locked_o", locked_o, m_locked);
  endtask

  task automatic return_credits(input int count);
    credit_i = 1'b1;
    repeat (count) @(posedge S_AXI_ACLK);
    #2;
    credit_i  = 1'b0;
    m_credits = m_credits + count;
    if (m_credits > `UPL_CREDIT_MAX) begin
      m_credits = `UPL_CREDIT_MAX;
    end
  endtask

  //////////////////////////////
  // Step table
  //////////////////////////////
  task automatic add_step(input logic [1:0] op, input int addr, input logic [31:0] data,
                          input int cnt, input logic [31:0] exp,
                          input uplink_pkg::axi_resp_t resp);
    step_t s;
    s.op   = op;
    s.addr = addr;
    s.data = data;
    s.cnt  = cnt;
    s.exp  = exp;
    s.resp = resp;
    steps.push_back(s);
  endtask

  // Status reads take their expected value from the model
  task automatic build_steps();
    // Reset values
    add_step(OP_RD,  0, 0, 0, 32'h0, R_OK);
    add_step(OP_RD,  4, 0, 0, 32'h0, R_OK);
    // Partial strobe, status write, holes
    add_step(OP_WR,  0, 32'hA5C3_5A3C, 4'b1010, 0, R_OK);
    add_step(OP_RD,  0, 0, 0, 32'hA500_5A00, R_OK);
    add_step(OP_WR,  4, 32'hFFFF_FFFF, 4'b1111, 0, R_OK);
    add_step(OP_RD,  4, 0, 0, 32'h0, R_OK);
    add_step(OP_RD,  0, 0, 0, 32'hA500_5A00, R_OK);
    add_step(OP_WR,  8, 32'hFFFF_FFFF, 4'b1111, 0, R_ERR);
    add_step(OP_RD,  8, 0, 0, 32'h0, R_ERR);
    // Control keeps its value after the hole write
    add_step(OP_RD,  0, 0, 0, 32'hA500_5A00, R_OK);
    add_step(OP_WR,  0, 32'h0, 4'b1111, 0, R_OK);
    // Lock at offset 5 until the credits run out
    add_step(OP_FRM, 5, 0, 40, 0, R_OK);
    add_step(OP_RD,  4, 0, 0, 0, R_OK);
    add_step(OP_CRD, 0, 0, 3, 0, R_OK);
    add_step(OP_FRM, 5, 0, 5, 0, R_OK);
    add_step(OP_CRD, 0, 0, 4, 0, R_OK);
    add_step(OP_FRM, 5, F_PERR, 2, 0, R_OK);
    add_step(OP_RD,  4, 0, 0, 0, R_OK);
    // Bad headers below and at the loss count
    add_step(OP_FRM, 5, F_HDR, 3, 0, R_OK);
    add_step(OP_RD,  4, 0, 0, 0, R_OK);
    add_step(OP_FRM, 5, 0, 1, 0, R_OK);
    add_step(OP_FRM, 5, F_HDR, 4, 0, R_OK);
    add_step(OP_RD,  4, 0, 0, 0, R_OK);
    // Inverted stream with polarity set
    add_step(OP_WR,  0, 32'h2, 4'b1111, 0, R_OK);
    add_step(OP_CRD, 0, 0, 4, 0, R_OK);
    add_step(OP_FRM, 9, F_INV, 40, 0, R_OK);
    add_step(OP_RD,  4, 0, 0, 0, R_OK);
    // Uplink reset pulse through control bit 0
    add_step(OP_WR,  0, 32'h3, 4'b0001, 0, R_OK);
    add_step(OP_WR,  0, 32'h2, 4'b0001, 0, R_OK);
    add_step(OP_RD,  4, 0, 0, 0, R_OK);
    add_step(OP_RD,  0, 0, 0, 32'h2, R_OK);
    add_step(OP_FRM, 9, F_INV, 40, 0, R_OK);
    add_step(OP_RD,  4, 0, 0, 0, R_OK);
  endtask

  initial begin
    S_AXI_ARESETN   = 1'b0;
    s_axi_awaddr_i  = '0;
    s_axi_awvalid_i = 1'b0;
    s_axi_wdata_i   = '0;
    s_axi_wstrb_i   = '0;
    s_axi_wvalid_i  = 1'b0;
    s_axi_bready_i  = 1'b1;
    s_axi_araddr_i  = '0;
    s_axi_arvalid_i = 1'b0;
    s_axi_rready_i  = 1'b1;
    mgt_word_i      = '0;
    mgt_valid_i     = 1'b0;
    credit_i        = 1'b0;
    lcg_state       = 32'd30;
    m_ctrl          = '0;
    cycle_cnt       = 0;
    cycle_limit     = 0;
    clear_uplink_model();
    build_steps();
    // Frame words plus 40 cycles per other step and then doubled
    foreach (steps[i]) begin
      cycle_limit += (steps[i].op == OP_FRM) ? int'(steps[i].cnt) : 40;
    end
    cycle_limit = cycle_limit * 2;
    repeat (10) @(posedge S_AXI_ACLK);
    #2;
    S_AXI_ARESETN = 1'b1;
    check_flag("user_valid_o", user_valid_o, 1'b0);
    foreach (steps[i]) begin
      case (steps[i].op)
        OP_WR: begin
          axi_write(steps[i].addr, steps[i].data, steps[i].cnt[3:0], steps[i].resp);
          if (steps[i].addr[10:2] == 0 && steps[i].resp == R_OK) begin
            apply_ctrl_write(steps[i].data, steps[i].cnt[3:0]);
          end
        end
        OP_RD: begin
          if (steps[i].addr == STAT_ADDR) begin
            axi_read(steps[i].addr, expected_status(), steps[i].resp);
          end else begin
            axi_read(steps[i].addr, steps[i].exp, steps[i].resp);
          end
        end
        OP_FRM: begin
          send_frames(steps[i].addr, steps[i].data, steps[i].cnt);
        end
        default: begin
          return_credits(steps[i].cnt);
        end
      endcase
    end
    $display("sim passed");
    $finish;
  end

endmodule

//--- sources.f
+incdir+hdl
hdl/uplink_pkg.sv
hdl/reg_bus_if.sv
hdl/axil_reg_slave.sv
hdl/uplink_regs.sv
hdl/frame_aligner.sv
hdl/frame_decoder.sv
hdl/uplink_top.sv
tb/tb_uplink_top.sv
